//--- logic/qdsp_cfg.svh
`ifndef QDSP_CFG_SVH
`define QDSP_CFG_SVH

// sample width of one ADC value
`define QDSP_DW 16

// samples per dsp clock on each stream
`define QDSP_TSLICE 4

// accumulation buffer address bits, x/y word pairs
`define QDSP_BUF_AW 5

// read port address bits
`define QDSP_LB_AW 8

// first status address, bit 7 set
`define QDSP_LB_STATUS 8'h80

`endif

//--- logic/qdsp_pkg.sv
`default_nettype none

`include "qdsp_cfg.svh"

package qdsp_pkg;

	typedef logic signed [`QDSP_DW-1:0] sample_t;

	// slice 0 sits in the low bits
	typedef logic [`QDSP_TSLICE*`QDSP_DW-1:0] slice_t;

	typedef logic signed [31:0] acc_t;

	typedef logic [15:0] count_t;

	// top bit doubles as full
	typedef logic [`QDSP_BUF_AW:0] buf_addr_t;

	typedef logic [`QDSP_LB_AW-1:0] lb_addr_t;

	typedef enum logic [1:0] {
		st_idle,
		st_window,
		st_report
	} meas_state_t;

	typedef struct packed {
		logic done;
		acc_t xacc;
		acc_t yacc;
	} meas_result_t;

endpackage

`default_nettype wire

//--- logic/meas_integrator.sv
`default_nettype none

`include "qdsp_cfg.svh"

module meas_integrator import qdsp_pkg::*; (
	input wire logic dsp,
	input wire logic reset,
	input wire slice_t adc_x,
	input wire slice_t adc_y,
	input wire count_t period,
	input wire count_t meas_len,
	output logic trig,
	output meas_result_t result
);

	count_t trig_cnt;
	count_t win_cnt;
	meas_state_t state;
	acc_t xacc;
	acc_t yacc;
	acc_t x_sum;
	acc_t y_sum;

	assign trig = (trig_cnt == period - 16'd1);

	always_ff @(posedge dsp) begin
		if (reset) begin
			trig_cnt <= '0;
		end else begin
			trig_cnt <= trig ? '0 : trig_cnt + 16'd1;
		end
	end

	// all samples of one clock, sign extended
	always_comb begin
		x_sum = '0;
		y_sum = '0;
		for (int i = 0; i < `QDSP_TSLICE; i++) begin
			x_sum = x_sum + acc_t'(sample_t'(adc_x[i*`QDSP_DW +: `QDSP_DW]));
			y_sum = y_sum + acc_t'(sample_t'(adc_y[i*`QDSP_DW +: `QDSP_DW]));
		end
	end

	always_ff @(posedge dsp) begin
		if (reset) begin
			state <= st_idle;
			win_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					win_cnt <= '0;
					if (trig) state <= st_window;
				end
				st_window: begin
					win_cnt <= win_cnt + 16'd1;
					if (win_cnt == meas_len - 16'd1) state <= st_report;
				end
				default: state <= st_idle; // report lasts one cycle
			endcase
		end
	end

	always_ff @(posedge dsp) begin
		if (state == st_idle && trig) begin
			xacc <= '0;
			yacc <= '0;
		end else if (state == st_window) begin
			xacc <= xacc + x_sum;
			yacc <= yacc + y_sum;
		end
	end

	assign result.done = (state == st_report);
	assign result.xacc = xacc;
	assign result.yacc = yacc;

endmodule

`default_nettype wire

//--- logic/slice_minmax.sv
`default_nettype none

`include "qdsp_cfg.svh"

module slice_minmax import qdsp_pkg::*; (
	input wire logic dsp,
	input wire logic reset,
	input wire logic trig,
	input wire slice_t adc_x,
	output sample_t x_min,
	output sample_t x_max
);

	sample_t slice_lo;
	sample_t slice_hi;
	sample_t samp;

	// extremes of this clock's samples
	always_comb begin
		slice_lo = sample_t'(adc_x[`QDSP_DW-1:0]);
		slice_hi = slice_lo;
		samp = slice_lo;
		for (int i = 1; i < `QDSP_TSLICE; i++) begin
			samp = sample_t'(adc_x[i*`QDSP_DW +: `QDSP_DW]);
			if (samp < slice_lo) slice_lo = samp;
			if (samp > slice_hi) slice_hi = samp;
		end
	end

	always_ff @(posedge dsp) begin
		if (reset) begin
			x_min <= {1'b0, {(`QDSP_DW-1){1'b1}}}; // empty range
			x_max <= {1'b1, {(`QDSP_DW-1){1'b0}}};
		end else if (trig) begin
			x_min <= slice_lo;
			x_max <= slice_hi;
		end else begin
			if (slice_lo < x_min) x_min <= slice_lo;
			if (slice_hi > x_max) x_max <= slice_hi;
		end
	end

endmodule

`default_nettype wire

//--- logic/acc_buffer.sv
`default_nettype none

`include "qdsp_cfg.svh"

module acc_buffer import qdsp_pkg::*; (
	input wire logic dsp,
	input wire logic reset,
	input wire logic start,
	input wire logic trig,
	input wire meas_result_t result,
	output logic full,
	input wire lb_addr_t buf_rd_addr,
	output acc_t buf_rd_data
);

	localparam int depth = 2 ** `QDSP_BUF_AW;

	acc_t mem [0:depth-1];
	buf_addr_t wr_addr;
	logic armed;
	logic x_wr;
	logic y_pend;
	logic wr_en;
	acc_t yacc_hold;
	acc_t wr_data;

	assign full = wr_addr[`QDSP_BUF_AW];
	assign x_wr = result.done & ~full;
	assign wr_en = x_wr | y_pend;
	assign wr_data = y_pend ? yacc_hold : result.xacc; // x first, y next cycle

	always_ff @(posedge dsp) begin
		if (reset) begin
			armed <= 1'b0;
			y_pend <= 1'b0;
			wr_addr <= {1'b1, {`QDSP_BUF_AW{1'b0}}}; // starts full
		end else begin
			y_pend <= x_wr;
			if (start) begin
				armed <= 1'b1;
			end else if (trig) begin
				armed <= 1'b0;
			end
			if (armed && trig) begin
				wr_addr <= '0;
			end else if (wr_en) begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge dsp) begin
		if (result.done) yacc_hold <= result.yacc;
	end

	always_ff @(posedge dsp) begin
		if (wr_en) mem[wr_addr[`QDSP_BUF_AW-1:0]] <= wr_data;
	end

	always_ff @(posedge dsp) begin
		buf_rd_data <= mem[buf_rd_addr[`QDSP_BUF_AW-1:0]];
	end

endmodule

`default_nettype wire

//--- logic/lb_readout.sv
`default_nettype none

`include "qdsp_cfg.svh"

module lb_readout import qdsp_pkg::*; (
	input wire logic dsp,
	input wire logic reset,
	input wire logic lb_read,
	input wire lb_addr_t lb_addr,
	output lb_addr_t buf_rd_addr,
	input wire acc_t buf_rd_data,
	input wire logic full,
	input wire sample_t x_min,
	input wire sample_t x_max,
	output acc_t lb_data,
	output logic lb_valid
);

	logic rd_s1;
	logic status_s1;
	lb_addr_t addr_s1;
	acc_t status_word;

	assign buf_rd_addr = lb_addr; // buffer registers its own read

	always_comb begin
		case (addr_s1)
			lb_addr_t'(`QDSP_LB_STATUS): status_word = acc_t'(full);
			lb_addr_t'(`QDSP_LB_STATUS + 1): status_word = acc_t'(x_min);
			lb_addr_t'(`QDSP_LB_STATUS + 2): status_word = acc_t'(x_max);
			default: status_word = '0;
		endcase
	end

	always_ff @(posedge dsp) begin
		if (reset) begin
			rd_s1 <= 1'b0;
			lb_valid <= 1'b0;
		end else begin
			rd_s1 <= lb_read;
			lb_valid <= rd_s1;
		end
	end

	always_ff @(posedge dsp) begin
		status_s1 <= lb_addr[`QDSP_LB_AW-1];
		addr_s1 <= lb_addr;
		if (rd_s1) lb_data <= status_s1 ? status_word : buf_rd_data;
	end

endmodule

`default_nettype wire

//--- logic/qdsp_meas.sv
`default_nettype none

module qdsp_meas import qdsp_pkg::*; (
	input wire logic dsp,
	input wire logic reset,
	input wire slice_t adc_x,
	input wire slice_t adc_y,
	input wire count_t period,
	input wire count_t meas_len,
	input wire logic start,
	input wire logic lb_read,
	input wire lb_addr_t lb_addr,
	output acc_t lb_data,
	output logic lb_valid,
	output logic full
);

	logic trig;
	meas_result_t result;
	sample_t x_min;
	sample_t x_max;
	lb_addr_t buf_rd_addr;
	acc_t buf_rd_data;

	meas_integrator i_meas (
		.dsp(dsp),
		.reset(reset),
		.adc_x(adc_x),
		.adc_y(adc_y),
		.period(period),
		.meas_len(meas_len),
		.trig(trig),
		.result(result)
	);

	slice_minmax i_minmax (
		.dsp(dsp),
		.reset(reset),
		.trig(trig),
		.adc_x(adc_x),
		.x_min(x_min),
		.x_max(x_max)
	);

	acc_buffer i_buf (
		.dsp(dsp),
		.reset(reset),
		.start(start),
		.trig(trig),
		.result(result),
		.full(full),
		.buf_rd_addr(buf_rd_addr),
		.buf_rd_data(buf_rd_data)
	);

	lb_readout i_readout (
		.dsp(dsp),
		.reset(reset),
		.lb_read(lb_read),
		.lb_addr(lb_addr),
		.buf_rd_addr(buf_rd_addr),
		.buf_rd_data(buf_rd_data),
		.full(full),
		.x_min(x_min),
		.x_max(x_max),
		.lb_data(lb_data),
		.lb_valid(lb_valid)
	);

endmodule

`default_nettype wire

//--- testbench/qdsp_meas_asserts.sv
`default_nettype none

module qdsp_meas_asserts (
	input wire logic dsp,
	input wire logic reset,
	input wire logic lb_read,
	input wire logic lb_valid,
	input wire logic done,
	input wire logic full,
	input wire logic buf_wr
);

	read_latency: assert property (@(posedge dsp) disable iff (reset)
		lb_valid == $past(lb_read, 2))
		else $error("lb_valid does not trail lb_read by exactly two cycles");

	done_single: assert property (@(posedge dsp) disable iff (reset)
		done |=> !done)
		else $error("result done high on two cycles in a row");

	// writes only land in a buffer with room
	no_write_full: assert property (@(posedge dsp) disable iff (reset)
		full |-> !buf_wr)
		else $error("buffer write while full");

	full_after_reset: assert property (@(posedge dsp)
		$fell(reset) |-> full)
		else $error("full low in the first cycle after reset");

endmodule

bind qdsp_meas qdsp_meas_asserts i_asserts (
	.dsp(dsp),
	.reset(reset),
	.lb_read(lb_read),
	.lb_valid(lb_valid),
	.done(result.done),
	.full(full),
	.buf_wr(i_buf.wr_en)
);

`default_nettype wire

//--- testbench/qdsp_meas_tb.sv
`default_nettype none

`include "qdsp_cfg.svh"

module qdsp_meas_tb import qdsp_pkg::*; ();

	localparam int n_rows = 5;
	localparam int words = 2 ** `QDSP_BUF_AW;
	localparam int wait_limit = 400;

	typedef struct packed {
		slice_t x;
		slice_t y;
		count_t period;
		count_t meas_len;
		logic [7:0] n_meas;
		sample_t x_min;
		sample_t x_max;
	} row_t;

	logic dsp;
	logic reset;
	slice_t adc_x;
	slice_t adc_y;
	count_t period;
	count_t meas_len;
	logic start;
	logic lb_read;
	lb_addr_t lb_addr;
	acc_t lb_data;
	logic lb_valid;
	logic full;

	row_t rows [0:n_rows-1];
	lb_addr_t status_addrs [0:5] = '{8'h80, 8'h81, 8'h82, 8'h83, 8'hc7, 8'hff};
	lb_addr_t rd_addr_q [$];
	acc_t rd_data_q [$];
	logic [31:0] lfsr;
	int errors;
	int checks;
	int tests;
	logic timed_out;

	qdsp_meas i_dut (
		.dsp(dsp),
		.reset(reset),
		.adc_x(adc_x),
		.adc_y(adc_y),
		.period(period),
		.meas_len(meas_len),
		.start(start),
		.lb_read(lb_read),
		.lb_addr(lb_addr),
		.lb_data(lb_data),
		.lb_valid(lb_valid),
		.full(full)
	);

	always #2 dsp = ~dsp;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic slice_t rand_slice();
		slice_t v;
		v = '0;
		for (int i = 0; i < $bits(slice_t); i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[$bits(slice_t)-2:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic slice_t make_slice(input int s0, input int s1, input int s2, input int s3);
		return {sample_t'(s3), sample_t'(s2), sample_t'(s1), sample_t'(s0)};
	endfunction

	function automatic sample_t lane(input slice_t s, input int i);
		return sample_t'(s[i*`QDSP_DW +: `QDSP_DW]);
	endfunction

	// one full window of a constant slice
	function automatic acc_t expected_sum(input slice_t s, input count_t len);
		acc_t total;
		total = 0;
		for (int i = 0; i < `QDSP_TSLICE; i++) begin
			total = total + acc_t'(lane(s, i));
		end
		return total * acc_t'(len);
	endfunction

	function automatic sample_t slice_extreme(input slice_t s, input logic want_max);
		sample_t best;
		best = lane(s, 0);
		for (int i = 1; i < `QDSP_TSLICE; i++) begin
			if (want_max && lane(s, i) > best) best = lane(s, i);
			if (!want_max && lane(s, i) < best) best = lane(s, i);
		end
		return best;
	endfunction

	function automatic void fill_table();
		rows[0] = '{x: make_slice(100, -50, 7, 1000), y: make_slice(3, 5, -8, 20),
			period: 16'd20, meas_len: 16'd5, n_meas: 8'd4,
			x_min: -16'sd50, x_max: 16'sd1000};
		rows[1] = '{x: make_slice(-300, -2, -32768, 12000), y: make_slice(-1, -1, -1, -1),
			period: 16'd24, meas_len: 16'd9, n_meas: 8'd18,
			x_min: 16'sh8000, x_max: 16'sd12000};
		rows[2] = '{x: make_slice(5, 5, 5, 5), y: make_slice(32767, 32767, 32767, 32767),
			period: 16'd12, meas_len: 16'd10, n_meas: 8'd3,
			x_min: 16'sd5, x_max: 16'sd5};
		for (int i = 3; i < n_rows; i++) begin
			rows[i].x = rand_slice();
			rows[i].y = rand_slice();
			rows[i].period = 16'd16;
			rows[i].meas_len = (i == 3) ? 16'd7 : 16'd14;
			rows[i].n_meas = (i == 3) ? 8'd5 : 8'd16;
			rows[i].x_min = slice_extreme(rows[i].x, 1'b0);
			rows[i].x_max = slice_extreme(rows[i].x, 1'b1);
		end
	endfunction

	task automatic check_value(input acc_t got, input acc_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s: got %0d (0x%08h), expected %0d (0x%08h)",
				$time, what, got, got, exp, exp);
		end
	endtask

	// trig and done are single-cycle pulses
	task automatic wait_event(input string what);
		int n;
		logic hit;
		n = 0;
		hit = 1'b0;
		while (!timed_out && !hit) begin
			@(negedge dsp);
			n++;
			hit = (what == "trig") ? i_dut.trig : i_dut.result.done;
			if (!hit && n >= wait_limit) begin
				timed_out = 1'b1;
				$display("timeout: no %s pulse within %0d cycles", what, wait_limit);
			end
		end
	endtask

	task automatic read_burst();
		int issued;
		int cyc;
		issued = 0;
		cyc = 0;
		rd_data_q.delete();
		while (!timed_out && rd_data_q.size() < rd_addr_q.size()) begin
			@(posedge dsp);
			lb_read <= (issued < rd_addr_q.size());
			if (issued < rd_addr_q.size()) begin
				lb_addr <= rd_addr_q[issued];
				issued++;
			end
			@(negedge dsp);
			if (lb_valid) begin
				check_value(acc_t'(cyc), acc_t'(rd_data_q.size() + 2), "lb_valid latency");
				rd_data_q.push_back(lb_data);
			end
			cyc++;
			if (cyc > rd_addr_q.size() + wait_limit) begin
				timed_out = 1'b1;
				$display("timeout: read data did not come back for every read strobe");
			end
		end
	endtask

	task automatic check_status(input logic full_exp, input sample_t min_exp, input sample_t max_exp);
		acc_t exp;
		rd_addr_q.delete();
		foreach (status_addrs[i]) rd_addr_q.push_back(status_addrs[i]);
		read_burst();
		for (int i = 0; i < rd_data_q.size(); i++) begin
			case (status_addrs[i])
				8'h80: exp = acc_t'(full_exp);
				8'h81: exp = acc_t'(min_exp); // sign extended
				8'h82: exp = acc_t'(max_exp);
				default: exp = '0;
			endcase
			check_value(rd_data_q[i], exp, $sformatf("status word 0x%02h", status_addrs[i]));
		end
	endtask

	task automatic check_buffer(input row_t r, input int pairs);
		rd_addr_q.delete();
		for (int k = 0; k < 2 * pairs; k++) rd_addr_q.push_back(lb_addr_t'(k));
		read_burst();
		for (int k = 0; k < rd_data_q.size(); k++) begin
			check_value(rd_data_q[k], expected_sum((k % 2 == 1) ? r.y : r.x, r.meas_len),
				$sformatf("buffer word %0d", k));
		end
	endtask

	task automatic run_row(input int idx);
		row_t r;
		int pairs;
		int errs_before;
		r = rows[idx];
		errs_before = errors;
		pairs = (r.n_meas > words / 2) ? words / 2 : int'(r.n_meas);
		wait_event("trig");
		@(posedge dsp); // counter restarts here, so a new period is safe
		adc_x <= r.x;
		adc_y <= r.y;
		period <= r.period;
		meas_len <= r.meas_len;
		start <= 1'b1;
		@(posedge dsp);
		start <= 1'b0;
		wait_event("trig"); // write address back to 0
		repeat (pairs) wait_event("done");
		repeat (2) @(negedge dsp); // y word lands one cycle after x
		check_value(acc_t'(full), acc_t'(r.n_meas >= words / 2), "full after the measurements");
		check_status(r.n_meas >= words / 2, r.x_min, r.x_max);
		if (r.n_meas > words / 2) begin
			@(posedge dsp);
			adc_x <= rand_slice();
			adc_y <= rand_slice();
			repeat (r.n_meas - words / 2) wait_event("done");
			check_value(acc_t'(full), 1, "full after dropped results");
		end
		check_buffer(r, pairs);
		tests++;
		$display("row %0d: period %0d meas_len %0d measurements %0d, %s", idx, r.period,
			r.meas_len, r.n_meas, (errors == errs_before && !timed_out) ? "ok" : "mismatch");
	endtask

	initial begin
		dsp = 1'b0;
		reset = 1'b1;
		adc_x = '0;
		adc_y = '0;
		period = 16'd20;
		meas_len = 16'd5;
		start = 1'b0;
		lb_read = 1'b0;
		lb_addr = '0;
		lfsr = 32'h1e2a_2191;
		errors = 0;
		checks = 0;
		tests = 0;
		timed_out = 1'b0;
		fill_table();
		repeat (10) @(posedge dsp);
		reset <= 1'b0;
		// measurements run but nothing is armed yet
		repeat (2) wait_event("done");
		check_value(acc_t'(full), 1, "full port before start");
		check_status(1'b1, '0, '0);
		tests++;
		$display("reset: buffer full before start, %s", (errors == 0 && !timed_out) ? "ok" : "mismatch");
		for (int i = 0; i < n_rows && !timed_out; i++) run_row(i);
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- qdsp_meas.f
+incdir+logic
logic/qdsp_pkg.sv
logic/meas_integrator.sv
logic/slice_minmax.sv
logic/acc_buffer.sv
logic/lb_readout.sv
logic/qdsp_meas.sv
testbench/qdsp_meas_asserts.sv
testbench/qdsp_meas_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f qdsp_meas.f \
	--top-module qdsp_meas_tb -Mdir obj_dir -o qdsp_meas_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/qdsp_meas_sim > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
